// ==== sim.f ====
+incdir+source
source/qsim_gate_pkg.sv
source/qsim_state_pkg.sv
source/gate_coo.sv
source/qsim_controller.sv
source/pe_unit.sv
source/cx_swapper.sv
source/state_mem.sv
source/qsim_top.sv
sim/tb_qsim.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal -f sim.f --top-module tb_qsim -o tb_qsim

out=$(./obj_dir/tb_qsim)
echo "$out"

if grep -qxF '** PASS **' <<< "$out"; then
    exit 0
fi
exit 1

// ==== sim/tb_qsim.sv ====
`include "qsim_defs.svh"

module tb_qsim;
    import qsim_gate_pkg::*;
    import qsim_state_pkg::*;

    localparam int GA_W    = $clog2(`QSIM_GATE_DEPTH);
    localparam int NUM_AMP = 2 ** `QSIM_MAX_QBITS;
    localparam int TIMEOUT = 2000;

    // Selectors 0 to 2 match the gate kind encoding
    localparam int SEL_SPARSE = 0;
    localparam int SEL_DENSE  = 1;
    localparam int SEL_CX     = 2;
    localparam int SEL_MIXED  = 3;

    logic            clk;
    logic            rst_n;
    logic            i_gate_wr;
    logic [GA_W-1:0] i_gate_addr;
    gate_word_s      i_gate_data;
    logic [GA_W:0]   i_gate_num;
    logic            i_vec_wr;
    amp_idx_t        i_vec_addr;
    amp_t            i_vec_wdata;
    amp_t            o_vec_rdata;
    logic            i_start;
    qbit_num_t       i_qbit_num;
    logic            o_done;

    logic [15:0] lfsr_state;
    amp_t        model [NUM_AMP];
    gate_word_s  gate_list [`QSIM_GATE_DEPTH];
    int          gate_cnt;
    int          err_cnt;
    int          chk_cnt;
    int          test_cnt;
    bit          aborted;

    qsim_top i_dut (
        .clk(clk), .rst_n(rst_n),
        .i_gate_wr(i_gate_wr), .i_gate_addr(i_gate_addr), .i_gate_data(i_gate_data),
        .i_gate_num(i_gate_num),
        .i_vec_wr(i_vec_wr), .i_vec_addr(i_vec_addr), .i_vec_wdata(i_vec_wdata),
        .o_vec_rdata(o_vec_rdata),
        .i_start(i_start), .i_qbit_num(i_qbit_num), .o_done(o_done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r          = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return r;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        test_cnt++;
        $display("test %0d %s finished with %0d errors", test_cnt, name,
                 err_cnt - errs_before);
    endtask

    function automatic gate_word_s make_gate(input int kind_sel, input int n);
        gate_word_s g;
        int         k;
        k      = (kind_sel == SEL_MIXED) ? int'(rand_bits(2) % 3) : kind_sel;
        g.kind = gate_kind_e'(k);
        if (g.kind == CX) begin
            g.payload.cx.ctrl   = 2'(rand_bits(2) % n);
            g.payload.cx.target = 2'(rand_bits(2) % n);
            g.payload.cx.rsvd   = 26'(rand_bits(26));
        end else begin
            g.payload.mat.target = 2'(rand_bits(2) % n);
            g.payload.mat.a      = coef_t'(rand_bits(7));
            g.payload.mat.b      = coef_t'(rand_bits(7));
            g.payload.mat.c      = coef_t'(rand_bits(7));
            g.payload.mat.d      = coef_t'(rand_bits(7));
        end
        return g;
    endfunction

    function automatic gate_word_s cx_gate(input int ctrl, input int target);
        gate_word_s g;
        g.kind              = CX;
        g.payload.cx.ctrl   = 2'(ctrl);
        g.payload.cx.target = 2'(target);
        g.payload.cx.rsvd   = '0;
        return g;
    endfunction

    // Every index with bit t clear starts a pair
    task automatic model_apply(input gate_word_s g, input int n);
        int t;
        int c;
        int i1;
        int x0;
        int x1;
        int a;
        int b;
        int cc;
        int d;
        int y0;
        int y1;
        t = (g.kind == CX) ? int'(g.payload.cx.target) : int'(g.payload.mat.target);
        c = g.payload.cx.ctrl;
        a = g.payload.mat.a;
        b = g.payload.mat.b;
        cc = g.payload.mat.c;
        d = g.payload.mat.d;
        for (int i = 0; i < (1 << n); i++) begin
            if (((i >> t) & 1) == 0) begin
                i1 = i | (1 << t);
                x0 = model[i];
                x1 = model[i1];
                if (g.kind == CX) begin
                    y0 = (((i >> c) & 1) == 1) ? x1 : x0;
                    y1 = (((i >> c) & 1) == 1) ? x0 : x1;
                end else if (g.kind == SPARSE) begin
                    y0 = (a * x0) >>> `QSIM_COEF_FRAC;
                    y1 = (d * x1) >>> `QSIM_COEF_FRAC;
                end else begin
                    y0 = (a * x0 + b * x1) >>> `QSIM_COEF_FRAC;
                    y1 = (cc * x0 + d * x1) >>> `QSIM_COEF_FRAC;
                end
                model[i]  = amp_t'(y0);
                model[i1] = amp_t'(y1);
            end
        end
    endtask

    task automatic write_amp(input int addr, input amp_t val);
        @(posedge clk);
        i_vec_wr    <= 1'b1;
        i_vec_addr  <= amp_idx_t'(addr);
        i_vec_wdata <= val;
        @(posedge clk);
        i_vec_wr <= 1'b0;
        model[addr] = val;
    endtask

    task automatic load_random_vector();
        for (int i = 0; i < NUM_AMP; i++) begin
            write_amp(i, amp_t'(rand_bits(16)));
        end
    endtask

    task automatic check_vector();
        for (int i = 0; i < NUM_AMP; i++) begin
            @(posedge clk);
            i_vec_addr <= amp_idx_t'(i);
            @(negedge clk);
            check($sformatf("o_vec_rdata[%0d]", i), 32'(o_vec_rdata), 32'(model[i]));
        end
    endtask

    task automatic build_list(input int kind_sel, input int n);
        gate_cnt = int'(rand_bits(3)) + 1;
        for (int j = 0; j < gate_cnt; j++) begin
            gate_list[j] = make_gate(kind_sel, n);
            model_apply(gate_list[j], n);
        end
    endtask

    task automatic load_gates();
        for (int j = 0; j < gate_cnt; j++) begin
            @(posedge clk);
            i_gate_wr   <= 1'b1;
            i_gate_addr <= GA_W'(j);
            i_gate_data <= gate_list[j];
        end
        @(posedge clk);
        i_gate_wr  <= 1'b0;
        i_gate_num <= (GA_W + 1)'(gate_cnt);
    endtask

    task automatic wait_done_level(input logic level, input string what, output bit ok);
        int cycles;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < TIMEOUT) begin
            @(negedge clk);
            ok = (o_done === level);
            cycles++;
        end
        if (!ok) begin
            $display("timeout: o_done never went to %0d after %s", level, what);
            aborted = 1'b1;
        end
    endtask

    task automatic start_run(input int n, output bit ok);
        @(posedge clk);
        i_qbit_num <= qbit_num_t'(n);
        i_start    <= 1'b1;
        wait_done_level(1'b1, "i_start rose", ok);
    endtask

    task automatic stop_run(output bit ok);
        @(posedge clk);
        i_start <= 1'b0;
        wait_done_level(1'b0, "i_start fell", ok);
    endtask

    task automatic execute(input int n);
        bit ok;
        start_run(n, ok);
        if (ok) begin
            stop_run(ok);
        end
        if (ok) begin
            check_vector();
        end
    endtask

    task automatic reset_defaults();
        int errs;
        errs = err_cnt;
        @(negedge clk);
        check("o_done", 32'(o_done), 32'h0);
        check_vector();
        end_test("reset", errs);
    endtask

    task automatic host_read_write();
        int   errs;
        int   addr;
        amp_t val;
        errs = err_cnt;
        repeat (24) begin
            addr = int'(rand_bits(4));
            val  = amp_t'(rand_bits(16));
            write_amp(addr, val);
        end
        check_vector();
        end_test("host read/write", errs);
    endtask

    task automatic gate_list_runs(input string name, input int kind_sel, input int runs);
        int errs;
        int n;
        int run;
        errs = err_cnt;
        run  = 0;
        while (run < runs && !aborted) begin
            n = int'(rand_bits(2)) + 1;
            load_random_vector();
            build_list(kind_sel, n);
            load_gates();
            execute(n);
            run++;
        end
        end_test(name, errs);
    endtask

    // First gate has ctrl equal to target
    task automatic cx_directed_list();
        int errs;
        errs = err_cnt;
        load_random_vector();
        gate_cnt     = 3;
        gate_list[0] = cx_gate(1, 1);
        gate_list[1] = cx_gate(0, 1);
        gate_list[2] = cx_gate(1, 0);
        for (int j = 0; j < gate_cnt; j++) begin
            model_apply(gate_list[j], 2);
        end
        load_gates();
        execute(2);
        end_test("cx directed", errs);
    endtask

    task automatic back_to_back_runs();
        int errs;
        int n;
        bit ok;
        errs = err_cnt;
        n    = int'(rand_bits(2)) + 1;
        load_random_vector();
        build_list(SEL_MIXED, n);
        load_gates();
        start_run(n, ok);
        if (ok) begin
            repeat (5) begin
                @(negedge clk);
                check("o_done", 32'(o_done), 32'h1);
            end
            stop_run(ok);
        end
        if (ok) begin
            check_vector();
            // Second run keeps the stored vector
            n = n % 4 + 1;
            build_list(SEL_MIXED, n);
            load_gates();
            execute(n);
        end
        end_test("back-to-back", errs);
    endtask

    initial begin
        lfsr_state  = 16'd56839;
        err_cnt     = 0;
        chk_cnt     = 0;
        test_cnt    = 0;
        aborted     = 1'b0;
        rst_n       = 1'b0;
        i_gate_wr   = 1'b0;
        i_gate_addr = '0;
        i_gate_data = '0;
        i_gate_num  = '0;
        i_vec_wr    = 1'b0;
        i_vec_addr  = '0;
        i_vec_wdata = '0;
        i_start     = 1'b0;
        i_qbit_num  = '0;
        for (int i = 0; i < NUM_AMP; i++) begin
            model[i] = '0;
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        reset_defaults();
        host_read_write();
        if (!aborted) gate_list_runs("dense", SEL_DENSE, 6);
        if (!aborted) gate_list_runs("sparse", SEL_SPARSE, 6);
        if (!aborted) cx_directed_list();
        if (!aborted) gate_list_runs("cx", SEL_CX, 6);
        if (!aborted) gate_list_runs("mixed", SEL_MIXED, 6);
        if (!aborted) back_to_back_runs();

        $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0 && !aborted) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== source/qsim_top.sv ====
`include "qsim_defs.svh"

module qsim_top (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                i_gate_wr,
    input  logic [$clog2(`QSIM_GATE_DEPTH)-1:0] i_gate_addr,
    input  qsim_gate_pkg::gate_word_s           i_gate_data,
    input  logic [$clog2(`QSIM_GATE_DEPTH):0]   i_gate_num,
    input  logic                                i_vec_wr,
    input  qsim_state_pkg::amp_idx_t            i_vec_addr,
    input  qsim_state_pkg::amp_t                i_vec_wdata,
    output qsim_state_pkg::amp_t                o_vec_rdata,
    input  logic                                i_start,
    input  qsim_state_pkg::qbit_num_t           i_qbit_num,
    output logic                                o_done
);
    import qsim_gate_pkg::*;
    import qsim_state_pkg::*;

    gate_word_s coo_gate;
    logic       start_coo, continue_coo, done_temporality, coo_last;
    logic       start_pe, start_cx, done_pe, done_cx, op_cx, sparse;
    qbit_idx_t  target, ctrl;
    coef_t      coef_a, coef_b, coef_c, coef_d;
    qbit_num_t  qbit_num;
    amp_idx_t   pe_addr0, pe_addr1, cx_addr0, cx_addr1;
    logic       pe_we, cx_we;
    amp_t       pe_wd0, pe_wd1, cx_wd0, cx_wd1, rd0, rd1;

    gate_coo u_gate_coo (
        .clk(clk), .rst_n(rst_n),
        .i_wr(i_gate_wr), .i_addr(i_gate_addr), .i_data(i_gate_data),
        .i_gate_num(i_gate_num), .i_start(start_coo), .i_continue(continue_coo),
        .o_gate(coo_gate), .o_done_temporality(done_temporality), .o_last(coo_last)
    );

    qsim_controller u_ctrl (
        .clk(clk), .rst_n(rst_n), .i_start(i_start), .i_qbit_num(i_qbit_num),
        .i_gate(coo_gate), .i_done_temporality(done_temporality), .i_last(coo_last),
        .i_done_pe(done_pe), .i_done_cx(done_cx),
        .o_start_coo(start_coo), .o_continue_coo(continue_coo),
        .o_start_pe(start_pe), .o_start_cx(start_cx), .o_op_cx(op_cx),
        .o_sparse(sparse), .o_target(target), .o_ctrl(ctrl),
        .o_coef_a(coef_a), .o_coef_b(coef_b), .o_coef_c(coef_c), .o_coef_d(coef_d),
        .o_qbit_num(qbit_num), .o_done(o_done)
    );

    pe_unit u_pe (
        .clk(clk), .rst_n(rst_n), .i_start(start_pe), .i_sparse(sparse),
        .i_target(target), .i_coef_a(coef_a), .i_coef_b(coef_b),
        .i_coef_c(coef_c), .i_coef_d(coef_d), .i_qbit_num(qbit_num),
        .i_rd0(rd0), .i_rd1(rd1), .o_addr0(pe_addr0), .o_addr1(pe_addr1),
        .o_we(pe_we), .o_wd0(pe_wd0), .o_wd1(pe_wd1), .o_done(done_pe)
    );

    cx_swapper u_cx (
        .clk(clk), .rst_n(rst_n), .i_start(start_cx), .i_ctrl(ctrl),
        .i_target(target), .i_qbit_num(qbit_num), .i_rd0(rd0), .i_rd1(rd1),
        .o_addr0(cx_addr0), .o_addr1(cx_addr1), .o_we(cx_we),
        .o_wd0(cx_wd0), .o_wd1(cx_wd1), .o_done(done_cx)
    );

    state_mem u_state_mem (
        .clk(clk), .rst_n(rst_n),
        .i_host_wr(i_vec_wr), .i_host_addr(i_vec_addr), .i_host_wdata(i_vec_wdata),
        .o_host_rdata(o_vec_rdata), .i_op_cx(op_cx),
        .i_pe_addr0(pe_addr0), .i_pe_addr1(pe_addr1), .i_pe_we(pe_we),
        .i_pe_wd0(pe_wd0), .i_pe_wd1(pe_wd1),
        .i_cx_addr0(cx_addr0), .i_cx_addr1(cx_addr1), .i_cx_we(cx_we),
        .i_cx_wd0(cx_wd0), .i_cx_wd1(cx_wd1),
        .o_rd0(rd0), .o_rd1(rd1)
    );

endmodule

// ==== source/state_mem.sv ====
`include "qsim_defs.svh"

module state_mem (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     i_host_wr,
    input  qsim_state_pkg::amp_idx_t i_host_addr,
    input  qsim_state_pkg::amp_t     i_host_wdata,
    output qsim_state_pkg::amp_t     o_host_rdata,
    input  logic                     i_op_cx,
    input  qsim_state_pkg::amp_idx_t i_pe_addr0,
    input  qsim_state_pkg::amp_idx_t i_pe_addr1,
    input  logic                     i_pe_we,
    input  qsim_state_pkg::amp_t     i_pe_wd0,
    input  qsim_state_pkg::amp_t     i_pe_wd1,
    input  qsim_state_pkg::amp_idx_t i_cx_addr0,
    input  qsim_state_pkg::amp_idx_t i_cx_addr1,
    input  logic                     i_cx_we,
    input  qsim_state_pkg::amp_t     i_cx_wd0,
    input  qsim_state_pkg::amp_t     i_cx_wd1,
    output qsim_state_pkg::amp_t     o_rd0,
    output qsim_state_pkg::amp_t     o_rd1
);
    import qsim_state_pkg::*;

    localparam int DEPTH = 2 ** `QSIM_MAX_QBITS;

    amp_t     amp_q [DEPTH];
    amp_idx_t addr0;
    amp_idx_t addr1;
    logic     we;
    amp_t     wd0;
    amp_t     wd1;

    // Pair port of the running engine
    assign addr0 = i_op_cx ? i_cx_addr0 : i_pe_addr0;
    assign addr1 = i_op_cx ? i_cx_addr1 : i_pe_addr1;
    assign we    = i_op_cx ? i_cx_we : i_pe_we;
    assign wd0   = i_op_cx ? i_cx_wd0 : i_pe_wd0;
    assign wd1   = i_op_cx ? i_cx_wd1 : i_pe_wd1;

    assign o_rd0        = amp_q[addr0];
    assign o_rd1        = amp_q[addr1];
    assign o_host_rdata = amp_q[i_host_addr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            amp_q <= '{default: '0};
        end else if (we) begin
            amp_q[addr0] <= wd0;
            amp_q[addr1] <= wd1;
        end else if (i_host_wr) begin
            amp_q[i_host_addr] <= i_host_wdata;
        end
    end

endmodule

// ==== source/cx_swapper.sv ====
`include "qsim_defs.svh"

module cx_swapper (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_start,
    input  qsim_state_pkg::qbit_idx_t i_ctrl,
    input  qsim_state_pkg::qbit_idx_t i_target,
    input  qsim_state_pkg::qbit_num_t i_qbit_num,
    input  qsim_state_pkg::amp_t      i_rd0,
    input  qsim_state_pkg::amp_t      i_rd1,
    output qsim_state_pkg::amp_idx_t  o_addr0,
    output qsim_state_pkg::amp_idx_t  o_addr1,
    output logic                      o_we,
    output qsim_state_pkg::amp_t      o_wd0,
    output qsim_state_pkg::amp_t      o_wd1,
    output logic                      o_done
);
    import qsim_state_pkg::*;

    localparam int CNT_W = `QSIM_MAX_QBITS - 1;

    logic             busy;
    logic [CNT_W-1:0] pair_cnt;
    logic [CNT_W-1:0] pair_last;
    amp_idx_t         low_mask;

    assign pair_last = CNT_W'((1 << (i_qbit_num - 1'b1)) - 1);
    assign low_mask  = (amp_idx_t'(1) << i_target) - 1'b1;
    assign o_addr0   = ((amp_idx_t'(pair_cnt) & ~low_mask) << 1)
                     | (amp_idx_t'(pair_cnt) & low_mask);
    assign o_addr1   = o_addr0 | (amp_idx_t'(1) << i_target);

    // Index0 has the target bit clear, so ctrl == target never writes
    assign o_we  = busy && o_addr0[i_ctrl];
    assign o_wd0 = i_rd1;
    assign o_wd1 = i_rd0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            pair_cnt <= '0;
            o_done   <= 1'b0;
        end else begin
            o_done <= busy && (pair_cnt == pair_last);
            if (i_start) begin
                busy     <= 1'b1;
                pair_cnt <= '0;
            end else if (busy) begin
                if (pair_cnt == pair_last) begin
                    busy <= 1'b0;
                end
                pair_cnt <= pair_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== source/pe_unit.sv ====
`include "qsim_defs.svh"

module pe_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_start,
    input  logic                      i_sparse,
    input  qsim_state_pkg::qbit_idx_t i_target,
    input  qsim_gate_pkg::coef_t      i_coef_a,
    input  qsim_gate_pkg::coef_t      i_coef_b,
    input  qsim_gate_pkg::coef_t      i_coef_c,
    input  qsim_gate_pkg::coef_t      i_coef_d,
    input  qsim_state_pkg::qbit_num_t i_qbit_num,
    input  qsim_state_pkg::amp_t      i_rd0,
    input  qsim_state_pkg::amp_t      i_rd1,
    output qsim_state_pkg::amp_idx_t  o_addr0,
    output qsim_state_pkg::amp_idx_t  o_addr1,
    output logic                      o_we,
    output qsim_state_pkg::amp_t      o_wd0,
    output qsim_state_pkg::amp_t      o_wd1,
    output logic                      o_done
);
    import qsim_state_pkg::*;

    localparam int PROD_W = `QSIM_AMP_W + `QSIM_COEF_W;
    localparam int CNT_W  = `QSIM_MAX_QBITS - 1;

    logic                     busy;
    logic [CNT_W-1:0]         pair_cnt;
    logic [CNT_W-1:0]         pair_last;
    amp_idx_t                 low_mask;
    logic signed [PROD_W-1:0] prod_a;
    logic signed [PROD_W-1:0] prod_b;
    logic signed [PROD_W-1:0] prod_c;
    logic signed [PROD_W-1:0] prod_d;
    logic signed [PROD_W:0]   sum0;
    logic signed [PROD_W:0]   sum1;

    // 2^(n-1) pairs per target qubit
    assign pair_last = CNT_W'((1 << (i_qbit_num - 1'b1)) - 1);

    // Insert a zero at the target bit of the pair count
    assign low_mask = (amp_idx_t'(1) << i_target) - 1'b1;
    assign o_addr0  = ((amp_idx_t'(pair_cnt) & ~low_mask) << 1)
                    | (amp_idx_t'(pair_cnt) & low_mask);
    assign o_addr1  = o_addr0 | (amp_idx_t'(1) << i_target);
    assign o_we     = busy;

    always_comb begin
        prod_a = i_coef_a * i_rd0;
        prod_b = i_coef_b * i_rd1;
        prod_c = i_coef_c * i_rd0;
        prod_d = i_coef_d * i_rd1;
        sum0   = prod_a;
        sum1   = prod_d;
        // Sparse gates keep the diagonal only
        if (!i_sparse) begin
            sum0 = sum0 + prod_b;
            sum1 = sum1 + prod_c;
        end
    end

    assign o_wd0 = amp_t'(sum0 >>> `QSIM_COEF_FRAC);
    assign o_wd1 = amp_t'(sum1 >>> `QSIM_COEF_FRAC);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            pair_cnt <= '0;
            o_done   <= 1'b0;
        end else begin
            o_done <= busy && (pair_cnt == pair_last);
            if (i_start) begin
                busy     <= 1'b1;
                pair_cnt <= '0;
            end else if (busy) begin
                if (pair_cnt == pair_last) begin
                    busy <= 1'b0;
                end
                pair_cnt <= pair_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== source/qsim_controller.sv ====
module qsim_controller (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_start,
    input  qsim_state_pkg::qbit_num_t i_qbit_num,
    input  qsim_gate_pkg::gate_word_s i_gate,
    input  logic                      i_done_temporality,
    input  logic                      i_last,
    input  logic                      i_done_pe,
    input  logic                      i_done_cx,
    output logic                      o_start_coo,
    output logic                      o_continue_coo,
    output logic                      o_start_pe,
    output logic                      o_start_cx,
    output logic                      o_op_cx,
    output logic                      o_sparse,
    output qsim_state_pkg::qbit_idx_t o_target,
    output qsim_state_pkg::qbit_idx_t o_ctrl,
    output qsim_gate_pkg::coef_t      o_coef_a,
    output qsim_gate_pkg::coef_t      o_coef_b,
    output qsim_gate_pkg::coef_t      o_coef_c,
    output qsim_gate_pkg::coef_t      o_coef_d,
    output qsim_state_pkg::qbit_num_t o_qbit_num,
    output logic                      o_done
);
    import qsim_gate_pkg::*;
    import qsim_state_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        GEN_MATRIX,
        LOAD_STATE,
        EXE,
        STORE_STATE,
        DONE
    } state_e;

    state_e     state;
    // Gate fetch requested, or engine running
    logic       sub_busy;
    logic       last_r;
    qbit_num_t  qbit_num_r;
    gate_word_s gate_r;

    // Field decode follows the gate kind
    assign o_sparse   = (gate_r.kind == SPARSE);
    assign o_target   = (gate_r.kind == CX) ? gate_r.payload.cx.target
                                            : gate_r.payload.mat.target;
    assign o_ctrl     = gate_r.payload.cx.ctrl;
    assign o_coef_a   = gate_r.payload.mat.a;
    assign o_coef_b   = gate_r.payload.mat.b;
    assign o_coef_c   = gate_r.payload.mat.c;
    assign o_coef_d   = gate_r.payload.mat.d;
    assign o_qbit_num = qbit_num_r;

    always_ff @(posedge clk) begin
        if (state == GEN_MATRIX && i_done_temporality) begin
            gate_r <= i_gate;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= IDLE;
            sub_busy       <= 1'b0;
            last_r         <= 1'b0;
            qbit_num_r     <= '0;
            o_start_coo    <= 1'b0;
            o_continue_coo <= 1'b0;
            o_start_pe     <= 1'b0;
            o_start_cx     <= 1'b0;
            o_op_cx        <= 1'b0;
            o_done         <= 1'b0;
        end else begin
            // Strobes last one cycle
            o_start_coo    <= 1'b0;
            o_continue_coo <= 1'b0;
            o_start_pe     <= 1'b0;
            o_start_cx     <= 1'b0;

            case (state)
                IDLE: begin
                    if (!i_start) begin
                        o_done <= 1'b0;
                    end else if (!o_done) begin
                        qbit_num_r  <= i_qbit_num;
                        o_start_coo <= 1'b1;
                        sub_busy    <= 1'b1;
                        state       <= GEN_MATRIX;
                    end
                end
                GEN_MATRIX: begin
                    if (!sub_busy) begin
                        o_continue_coo <= 1'b1;
                        sub_busy       <= 1'b1;
                    end else if (i_done_temporality) begin
                        last_r   <= i_last;
                        sub_busy <= 1'b0;
                        state    <= LOAD_STATE;
                    end
                end
                LOAD_STATE: begin
                    state <= EXE;
                end
                EXE: begin
                    if (!sub_busy) begin
                        sub_busy <= 1'b1;
                        if (gate_r.kind == CX) begin
                            o_start_cx <= 1'b1;
                            o_op_cx    <= 1'b1;
                        end else begin
                            o_start_pe <= 1'b1;
                        end
                    end else if (i_done_pe || i_done_cx) begin
                        sub_busy <= 1'b0;
                        o_op_cx  <= 1'b0;
                        state    <= STORE_STATE;
                    end
                end
                STORE_STATE: begin
                    state <= last_r ? DONE : GEN_MATRIX;
                end
                DONE: begin
                    o_done <= 1'b1;
                    state  <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// ==== source/gate_coo.sv ====
`include "qsim_defs.svh"

module gate_coo (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                i_wr,
    input  logic [$clog2(`QSIM_GATE_DEPTH)-1:0] i_addr,
    input  qsim_gate_pkg::gate_word_s           i_data,
    input  logic [$clog2(`QSIM_GATE_DEPTH):0]   i_gate_num,
    input  logic                                i_start,
    input  logic                                i_continue,
    output qsim_gate_pkg::gate_word_s           o_gate,
    output logic                                o_done_temporality,
    output logic                                o_last
);
    import qsim_gate_pkg::*;

    localparam int PTR_W = $clog2(`QSIM_GATE_DEPTH);

    gate_word_s       list_mem [`QSIM_GATE_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] nxt_ptr;
    logic             fetch;

    assign fetch   = i_start || i_continue;
    // Start rewinds the list, continue steps to the next entry
    assign nxt_ptr = i_start ? '0 : rd_ptr + 1'b1;

    always_ff @(posedge clk) begin
        if (i_wr) begin
            list_mem[i_addr] <= i_data;
        end
        if (fetch) begin
            o_gate <= list_mem[nxt_ptr];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr             <= '0;
            o_done_temporality <= 1'b0;
            o_last             <= 1'b0;
        end else begin
            o_done_temporality <= fetch;
            if (fetch) begin
                rd_ptr <= nxt_ptr;
                o_last <= ({1'b0, nxt_ptr} == i_gate_num - 1'b1);
            end
        end
    end

endmodule

// ==== source/qsim_state_pkg.sv ====
`include "qsim_defs.svh"

package qsim_state_pkg;

    typedef logic signed [`QSIM_AMP_W-1:0] amp_t;

    typedef logic [`QSIM_MAX_QBITS-1:0] amp_idx_t;

    typedef logic [$clog2(`QSIM_MAX_QBITS)-1:0] qbit_idx_t;

    // Qubit count, 1 up to the maximum
    typedef logic [$clog2(`QSIM_MAX_QBITS):0] qbit_num_t;

endpackage

// ==== source/qsim_gate_pkg.sv ====
`include "qsim_defs.svh"

package qsim_gate_pkg;

    typedef enum logic [1:0] {
        SPARSE = 2'b00,
        DENSE  = 2'b01,
        CX     = 2'b10
    } gate_kind_e;

    typedef logic signed [`QSIM_COEF_W-1:0] coef_t;

    // Single-qubit gate, row-major 2x2 matrix
    typedef struct packed {
        logic [1:0] target;
        coef_t      a;
        coef_t      b;
        coef_t      c;
        coef_t      d;
    } gate_mat_s;

    typedef struct packed {
        logic [1:0]  ctrl;
        logic [1:0]  target;
        logic [25:0] rsvd;
    } gate_cx_s;

    // Meaning of the payload depends on the kind field
    typedef union packed {
        gate_mat_s mat;
        gate_cx_s  cx;
    } gate_payload_u;

    typedef struct packed {
        gate_kind_e    kind;
        gate_payload_u payload;
    } gate_word_s;

endpackage

// ==== source/qsim_defs.svh ====
`ifndef QSIM_DEFS_SVH
`define QSIM_DEFS_SVH

// Largest supported register, 16 amplitudes
`define QSIM_MAX_QBITS 4

// Signed amplitude width
`define QSIM_AMP_W 16

// Signed matrix coefficient, Q1.5
`define QSIM_COEF_W 7
`define QSIM_COEF_FRAC 5

// Entries in the gate list
`define QSIM_GATE_DEPTH 8

`endif
